// File: src.f
verilog/nco_fmt_pkg.sv
verilog/nco_csr_pkg.sv
verilog/nco_csr.sv
verilog/nco_period_fifo.sv
verilog/nco_sync.sv
verilog/nco_core.sv
verilog/nco_top.sv
sim/nco_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module nco_tb -o nco_sim || exit 1
out=$(./obj_dir/nco_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF "All tests passed!" && exit 0 || exit 1

// File: sim/nco_tb.sv
`timescale 1ns/1ps
`default_nettype none

module nco_tb;

   import nco_fmt_pkg::*;
   import nco_csr_pkg::*;

   // one clk_in cycle in fixed point
   localparam int UNIT         = 1 << FRAC_W;
   localparam int TICK_TIMEOUT = 64;
   localparam int IDLE_WINDOW  = 32;
   localparam int LOAD_TIMEOUT = 64;
   localparam int GAPS         = 8;

   logic        clk;
   logic        clk_in;
   logic        rst;
   csr_addr_t   csr_addr;
   csr_data_t   csr_wdata;
   logic        csr_wen;
   logic        csr_ren;
   csr_data_t   csr_rdata;
   logic        tick;
   logic [15:0] lfsr_q;
   int          checks;
   int          errors;
   int          timeouts;

   nco_top UUT (
      .clk_i      (clk),
      .rst_i      (rst),
      .clk_in_i   (clk_in),
      .csr_addr_i (csr_addr),
      .csr_wdata_i(csr_wdata),
      .csr_wen_i  (csr_wen),
      .csr_ren_i  (csr_ren),
      .csr_rdata_o(csr_rdata),
      .tick_o     (tick)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      clk_in = 1'b0;
      forever #3 clk_in = ~clk_in;
   end

   // x^16 + x^14 + x^13 + x^11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_bits(input int n, output int val);
      val = 0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         val = (val << 1) | int'(lfsr_q[0]);
      end
   endtask

   // cycle of tick n after a load, ceil(n * p / 2^FRAC_W)
   function automatic int tick_cycle(input int n, input int p);
      return (n * p + UNIT - 1) / UNIT;
   endfunction

   task automatic check_csr(input string name, input csr_data_t got, input csr_data_t exp);
      checks++;
      if (got !== exp) begin
         $display("FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_cycles(input string name, input int got, input int exp);
      checks++;
      if (got !== exp) begin
         $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
      @(posedge clk);
      #1;
      csr_addr  = addr;
      csr_wdata = data;
      csr_wen   = 1'b1;
      @(posedge clk);
      #1;
      csr_wen = 1'b0;
   endtask

   task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
      @(posedge clk);
      #1;
      csr_addr = addr;
      csr_ren  = 1'b1;
      @(posedge clk);
      #1;
      csr_ren = 1'b0;
      data    = csr_rdata;
   endtask

   // cycles from the next tick to the tick gaps later
   task automatic measure_ticks(input int gaps, output int cycles);
      int   waited;
      int   seen;
      logic found;
      found  = 1'b0;
      waited = 0;
      while (!found && waited < TICK_TIMEOUT) begin
         @(negedge clk_in);
         waited++;
         found = (tick === 1'b1);
      end
      seen   = 0;
      cycles = 0;
      while (found && seen < gaps && cycles < TICK_TIMEOUT * gaps) begin
         @(negedge clk_in);
         cycles++;
         if (tick === 1'b1) begin
            seen++;
         end
      end
      if (!found || seen < gaps) begin
         $display("timed out waiting for a tick");
         timeouts++;
         cycles = -1;
      end
   endtask

   task automatic wait_tick_idle();
      int quiet;
      int waited;
      quiet  = 0;
      waited = 0;
      while (quiet < IDLE_WINDOW && waited < 8 * IDLE_WINDOW) begin
         @(negedge clk_in);
         waited++;
         quiet = (tick === 1'b1) ? 0 : quiet + 1;
      end
      if (quiet < IDLE_WINDOW) begin
         $display("ticks did not stop after enable was cleared");
         timeouts++;
      end
   endtask

   task automatic wait_load();
      int   waited;
      logic seen;
      waited = 0;
      seen   = 1'b0;
      while (!seen && waited < LOAD_TIMEOUT) begin
         @(negedge clk_in);
         waited++;
         seen = (UUT.nco_period_load === 1'b1);
      end
      if (!seen) begin
         $display("period load never reached the core");
         timeouts++;
      end
   endtask

   // load with the core stopped so the accumulator starts from zero
   task automatic restart_with_period(input period_t p);
      csr_write(ADDR_CTRL, 32'h0);
      wait_tick_idle();
      csr_write(ADDR_PERIOD, csr_data_t'(p));
      wait_load();
      csr_write(ADDR_CTRL, 32'h1);
   endtask

   task automatic check_ceiling(input string name, input period_t p);
      int c;
      measure_ticks(GAPS, c);
      check_cycles(name, c, tick_cycle(GAPS + 1, int'(p)) - tick_cycle(1, int'(p)));
   endtask

   task automatic test_reset_values();
      csr_data_t rd;
      csr_read(ADDR_CTRL, rd);
      check_csr("CTRL after reset", rd, 32'h0);
      csr_read(ADDR_STATUS, rd);
      check_csr("STATUS after reset", rd, 32'h0);
   endtask

   task automatic test_integer_period();
      int c;
      restart_with_period(period_t'(5 * UNIT));
      for (int i = 0; i < 4; i++) begin
         measure_ticks(1, c);
         check_cycles("tick gap at 5.0", c, 5);
      end
   endtask

   task automatic test_fractional_periods();
      int      r;
      period_t p;
      for (int i = 0; i < 4; i++) begin
         take_bits(11, r);
         p = period_t'(UNIT + r);
         restart_with_period(p);
         check_ceiling("ticks at random period", p);
      end
   endtask

   task automatic test_enable_toggle();
      int c;
      restart_with_period(period_t'(4 * UNIT));
      measure_ticks(1, c);
      check_cycles("tick gap before disable", c, 4);
      csr_write(ADDR_CTRL, 32'h0);
      wait_tick_idle();
      csr_write(ADDR_CTRL, 32'h1);
      for (int i = 0; i < 3; i++) begin
         measure_ticks(1, c);
         check_cycles("tick gap after enable", c, 4);
      end
   endtask

   task automatic test_overflow_burst();
      csr_data_t rd;
      int        tries;
      csr_write(ADDR_CTRL, 32'h0);
      wait_tick_idle();
      @(posedge clk);
      #1;
      csr_addr  = ADDR_PERIOD;
      csr_wdata = csr_data_t'(3 * UNIT);
      csr_wen   = 1'b1;
      repeat (16) @(posedge clk);
      #1;
      csr_wen = 1'b0;
      // let the FIFO drain before the status check
      tries = 0;
      csr_read(ADDR_STATUS, rd);
      while (rd[STAT_FULL_BIT] && tries < 32) begin
         csr_read(ADDR_STATUS, rd);
         tries++;
      end
      if (rd[STAT_FULL_BIT]) begin
         $display("period FIFO did not drain after the burst");
         timeouts++;
      end
      check_csr("STATUS after burst", rd, csr_data_t'(1) << STAT_OVF_BIT);
   endtask

   task automatic test_soft_reset();
      csr_data_t rd;
      csr_write(ADDR_CTRL, csr_data_t'(1) << CTRL_SRST_BIT);
      // long enough for the oscillator domain to see it
      repeat (6) @(posedge clk_in);
      csr_write(ADDR_CTRL, 32'h0);
      csr_read(ADDR_STATUS, rd);
      check_csr("STATUS after soft reset", rd, 32'h0);
      csr_read(ADDR_CTRL, rd);
      check_csr("CTRL after soft reset", rd, 32'h0);
      restart_with_period(period_t'(UNIT * 2 + UNIT * 3 / 4));
      check_ceiling("ticks after soft reset", period_t'(UNIT * 2 + UNIT * 3 / 4));
   endtask

   initial begin
      checks    = 0;
      errors    = 0;
      timeouts  = 0;
      lfsr_q    = 16'd73;
      rst       = 1'b1;
      csr_addr  = '0;
      csr_wdata = '0;
      csr_wen   = 1'b0;
      csr_ren   = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;

      test_reset_values();
      test_integer_period();
      test_fractional_periods();
      test_enable_toggle();
      test_overflow_burst();
      test_soft_reset();

      $display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/nco_top.sv
`timescale 1ns/1ps
`default_nettype none

module nco_top #(
   parameter int PERIOD_W = nco_fmt_pkg::PERIOD_W,
   parameter int FRAC_W   = nco_fmt_pkg::FRAC_W
) (
   input  wire logic                   clk_i,
   input  wire logic                   rst_i,
   input  wire logic                   clk_in_i,
   input  wire nco_csr_pkg::csr_addr_t csr_addr_i,
   input  wire nco_csr_pkg::csr_data_t csr_wdata_i,
   input  wire logic                   csr_wen_i,
   input  wire logic                   csr_ren_i,
   output nco_csr_pkg::csr_data_t      csr_rdata_o,
   output logic                        tick_o
);

   import nco_fmt_pkg::*;

   // bus domain settings
   logic    soft_reset;
   logic    enable;
   period_t period_wdata;
   logic    period_wen;
   logic    period_full;

   // oscillator domain settings
   logic    nco_rst;
   logic    nco_enable;
   period_t nco_period;
   logic    nco_period_load;

   nco_csr #(
      .PERIOD_W(PERIOD_W),
      .FRAC_W  (FRAC_W)
   ) csr (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .csr_addr_i    (csr_addr_i),
      .csr_wdata_i   (csr_wdata_i),
      .csr_wen_i     (csr_wen_i),
      .csr_ren_i     (csr_ren_i),
      .period_full_i (period_full),
      .csr_rdata_o   (csr_rdata_o),
      .soft_reset_o  (soft_reset),
      .enable_o      (enable),
      .period_wdata_o(period_wdata),
      .period_wen_o  (period_wen)
   );

   nco_sync #(
      .PERIOD_W(PERIOD_W)
   ) sync (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .clk_in_i      (clk_in_i),
      .soft_reset_i  (soft_reset),
      .enable_i      (enable),
      .period_wdata_i(period_wdata),
      .period_wen_i  (period_wen),
      .period_full_o (period_full),
      .nco_rst_o     (nco_rst),
      .enable_o      (nco_enable),
      .period_wdata_o(nco_period),
      .period_wen_o  (nco_period_load)
   );

   nco_core #(
      .PERIOD_W(PERIOD_W),
      .FRAC_W  (FRAC_W)
   ) core (
      .clk_in_i     (clk_in_i),
      .rst_i        (nco_rst),
      .enable_i     (nco_enable),
      .period_i     (nco_period),
      .period_load_i(nco_period_load),
      .tick_o       (tick_o)
   );

endmodule

`default_nettype wire

// File: verilog/nco_core.sv
`timescale 1ns/1ps
`default_nettype none

module nco_core #(
   parameter int PERIOD_W = nco_fmt_pkg::PERIOD_W,
   parameter int FRAC_W   = nco_fmt_pkg::FRAC_W
) (
   input  wire logic            clk_in_i,
   input  wire logic            rst_i,
   input  wire logic            enable_i,
   input  wire nco_fmt_pkg::period_t period_i,
   input  wire logic            period_load_i,
   output logic                 tick_o
);

   import nco_fmt_pkg::*;

   // one clk_in_i cycle in fixed point
   localparam acc_t    ONE      = acc_t'(1) << FRAC_W;
   localparam period_t ONE_CYC  = period_t'(ONE);

   period_t           period_q;
   acc_t              acc_q;
   logic [PERIOD_W:0] acc_sum;
   logic              wrap;
   logic              tick_q;

   assign acc_sum = acc_q + ONE;

   // period >= 1.0, so at most one wrap per cycle
   assign wrap = (acc_sum >= {1'b0, period_q});

   always_ff @(posedge clk_in_i) begin
      if (rst_i) begin
         period_q <= ONE_CYC;
         acc_q    <= '0;
         tick_q   <= 1'b0;
      end else if (period_load_i) begin
         period_q <= period_i;
         acc_q    <= '0;
         tick_q   <= 1'b0;
      end else if (enable_i) begin
         if (wrap) begin
            acc_q <= acc_sum - {1'b0, period_q};
         end else begin
            acc_q <= acc_sum;
         end
         tick_q <= wrap;
      end else begin
         // phase held while disabled
         tick_q <= 1'b0;
      end
   end

   assign tick_o = tick_q;

   // the register bank clamps writes, so nothing below 1.0 gets here
   a_period_min: assert property (@(posedge clk_in_i) disable iff (rst_i)
      period_load_i |=> period_q >= ONE_CYC);

endmodule

`default_nettype wire

// File: verilog/nco_sync.sv
`timescale 1ns/1ps
`default_nettype none

module nco_sync #(
   parameter int PERIOD_W = nco_fmt_pkg::PERIOD_W,
   parameter int FIFO_AW  = 1
) (
   input  wire logic            clk_i,
   input  wire logic            rst_i,
   input  wire logic            clk_in_i,
   input  wire logic            soft_reset_i,
   input  wire logic            enable_i,
   input  wire nco_fmt_pkg::period_t period_wdata_i,
   input  wire logic            period_wen_i,
   output logic                 period_full_o,
   output logic                 nco_rst_o,
   output logic                 enable_o,
   output nco_fmt_pkg::period_t period_wdata_o,
   output logic                 period_wen_o
);

   import nco_fmt_pkg::*;

   logic [1:0] rst_sync_q;
   logic [1:0] soft_sync_q;
   logic [1:0] en_sync_q;
   logic       fifo_w_rst;
   logic       fifo_empty;
   logic       fifo_pop;
   period_t    fifo_rdata;
   period_t    period_q;
   logic       period_wen_q;

   // bus reset into the oscillator domain
   always_ff @(posedge clk_in_i) begin
      rst_sync_q <= {rst_sync_q[0], rst_i};
   end

   always_ff @(posedge clk_in_i) begin
      if (rst_sync_q[1]) begin
         soft_sync_q <= '0;
         en_sync_q   <= '0;
      end else begin
         soft_sync_q <= {soft_sync_q[0], soft_reset_i};
         en_sync_q   <= {en_sync_q[0], enable_i};
      end
   end

   assign nco_rst_o  = rst_sync_q[1] | soft_sync_q[1];
   assign enable_o   = en_sync_q[1];
   assign fifo_w_rst = rst_i | soft_reset_i;

   // drain whenever something is queued
   assign fifo_pop = !fifo_empty;

   nco_period_fifo #(
      .PERIOD_W(PERIOD_W),
      .FIFO_AW (FIFO_AW)
   ) period_fifo (
      .w_clk_i  (clk_i),
      .w_rst_i  (fifo_w_rst),
      .w_en_i   (period_wen_i),
      .w_data_i (period_wdata_i),
      .w_full_o (period_full_o),
      .r_clk_i  (clk_in_i),
      .r_rst_i  (nco_rst_o),
      .r_en_i   (fifo_pop),
      .r_data_o (fifo_rdata),
      .r_empty_o(fifo_empty)
   );

   always_ff @(posedge clk_in_i) begin
      if (nco_rst_o) begin
         period_wen_q <= 1'b0;
      end else begin
         period_wen_q <= fifo_pop;
      end
   end

   always_ff @(posedge clk_in_i) begin
      if (fifo_pop) begin
         period_q <= fifo_rdata;
      end
   end

   assign period_wdata_o = period_q;
   assign period_wen_o   = period_wen_q;

endmodule

`default_nettype wire

// File: verilog/nco_period_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module nco_period_fifo #(
   parameter int PERIOD_W = nco_fmt_pkg::PERIOD_W,
   parameter int FIFO_AW  = 1
) (
   // write side
   input  wire logic            w_clk_i,
   input  wire logic            w_rst_i,
   input  wire logic            w_en_i,
   input  wire nco_fmt_pkg::period_t w_data_i,
   output logic                 w_full_o,

   // read side
   input  wire logic            r_clk_i,
   input  wire logic            r_rst_i,
   input  wire logic            r_en_i,
   output nco_fmt_pkg::period_t r_data_o,
   output logic                 r_empty_o
);

   localparam int DEPTH = 1 << FIFO_AW;
   localparam int PTR_W = FIFO_AW + 1;

   typedef logic [PTR_W-1:0] ptr_t;

   // top two gray bits differ when the writer is one lap ahead
   localparam ptr_t FULL_MASK = ptr_t'(3) << (FIFO_AW - 1);

   logic [PERIOD_W-1:0] mem_q [DEPTH];

   ptr_t w_bin_q;
   ptr_t w_gray_q;
   ptr_t w_bin_nxt;
   ptr_t w_gray_nxt;
   ptr_t r_gray_meta_q;
   ptr_t r_gray_sync_q;
   logic w_full_q;
   logic w_push;

   ptr_t r_bin_q;
   ptr_t r_gray_q;
   ptr_t r_bin_nxt;
   ptr_t r_gray_nxt;
   ptr_t w_gray_meta_q;
   ptr_t w_gray_sync_q;
   logic r_empty_q;
   logic r_pop;

   function automatic ptr_t bin2gray(input ptr_t bin);
      return bin ^ (bin >> 1);
   endfunction

   // write domain
   assign w_push     = w_en_i && !w_full_q;
   assign w_bin_nxt  = w_bin_q + ptr_t'(w_push);
   assign w_gray_nxt = bin2gray(w_bin_nxt);

   always_ff @(posedge w_clk_i) begin
      if (w_rst_i) begin
         w_bin_q       <= '0;
         w_gray_q      <= '0;
         r_gray_meta_q <= '0;
         r_gray_sync_q <= '0;
         w_full_q      <= 1'b0;
      end else begin
         w_bin_q       <= w_bin_nxt;
         w_gray_q      <= w_gray_nxt;
         r_gray_meta_q <= r_gray_q;
         r_gray_sync_q <= r_gray_meta_q;
         w_full_q      <= (w_gray_nxt == (r_gray_sync_q ^ FULL_MASK));
      end
   end

   always_ff @(posedge w_clk_i) begin
      if (w_push) begin
         mem_q[w_bin_q[FIFO_AW-1:0]] <= w_data_i;
      end
   end

   // read domain
   assign r_pop      = r_en_i && !r_empty_q;
   assign r_bin_nxt  = r_bin_q + ptr_t'(r_pop);
   assign r_gray_nxt = bin2gray(r_bin_nxt);

   always_ff @(posedge r_clk_i) begin
      if (r_rst_i) begin
         r_bin_q       <= '0;
         r_gray_q      <= '0;
         w_gray_meta_q <= '0;
         w_gray_sync_q <= '0;
         r_empty_q     <= 1'b1;
      end else begin
         r_bin_q       <= r_bin_nxt;
         r_gray_q      <= r_gray_nxt;
         w_gray_meta_q <= w_gray_q;
         w_gray_sync_q <= w_gray_meta_q;
         r_empty_q     <= (r_gray_nxt == w_gray_sync_q);
      end
   end

   // first word fall-through
   assign r_data_o  = mem_q[r_bin_q[FIFO_AW-1:0]];
   assign r_empty_o = r_empty_q;
   assign w_full_o  = w_full_q;

   a_no_write_full: assert property (@(posedge w_clk_i) disable iff (w_rst_i)
      w_en_i |-> !w_full_o);

   a_no_read_empty: assert property (@(posedge r_clk_i) disable iff (r_rst_i)
      r_en_i |-> !r_empty_o);

endmodule

`default_nettype wire

// File: verilog/nco_csr.sv
`timescale 1ns/1ps
`default_nettype none

module nco_csr #(
   parameter int PERIOD_W = nco_fmt_pkg::PERIOD_W,
   parameter int FRAC_W   = nco_fmt_pkg::FRAC_W
) (
   input  wire logic                  clk_i,
   input  wire logic                  rst_i,
   input  wire nco_csr_pkg::csr_addr_t csr_addr_i,
   input  wire nco_csr_pkg::csr_data_t csr_wdata_i,
   input  wire logic                  csr_wen_i,
   input  wire logic                  csr_ren_i,
   input  wire logic                  period_full_i,
   output nco_csr_pkg::csr_data_t     csr_rdata_o,
   output logic                       soft_reset_o,
   output logic                       enable_o,
   output nco_fmt_pkg::period_t       period_wdata_o,
   output logic                       period_wen_o
);

   import nco_csr_pkg::*;
   import nco_fmt_pkg::*;

   // one tick per cycle is the fastest the core can follow
   localparam period_t PERIOD_MIN = period_t'(1) << FRAC_W;

   logic      enable_q;
   logic      soft_q;
   logic      overflow_q;
   logic      period_wr;
   logic      period_drop;
   period_t   period_raw;
   csr_data_t rdata_q;

   assign period_wr   = csr_wen_i && (csr_addr_i == ADDR_PERIOD);
   assign period_drop = period_wr && period_full_i;
   assign period_raw  = csr_wdata_i[PERIOD_W-1:0];

   // straight to the FIFO write port when there is room
   assign period_wen_o   = period_wr && !period_full_i;
   assign period_wdata_o = (period_raw < PERIOD_MIN) ? PERIOD_MIN : period_raw;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         enable_q   <= 1'b0;
         soft_q     <= 1'b0;
         overflow_q <= 1'b0;
      end else begin
         if (csr_wen_i && (csr_addr_i == ADDR_CTRL)) begin
            enable_q <= csr_wdata_i[CTRL_EN_BIT];
            soft_q   <= csr_wdata_i[CTRL_SRST_BIT];
         end
         // sticky until soft reset
         if (soft_q) begin
            overflow_q <= 1'b0;
         end else if (period_drop) begin
            overflow_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rdata_q <= '0;
      end else begin
         rdata_q <= '0;
         if (csr_ren_i) begin
            case (csr_addr_i)
               ADDR_CTRL: begin
                  rdata_q[CTRL_EN_BIT]   <= enable_q;
                  rdata_q[CTRL_SRST_BIT] <= soft_q;
               end
               ADDR_STATUS: begin
                  rdata_q[STAT_FULL_BIT] <= period_full_i;
                  rdata_q[STAT_OVF_BIT]  <= overflow_q;
               end
               default: rdata_q <= '0;
            endcase
         end
      end
   end

   assign csr_rdata_o  = rdata_q;
   assign enable_o     = enable_q;
   assign soft_reset_o = soft_q;

endmodule

`default_nettype wire

// File: verilog/nco_csr_pkg.sv
`default_nettype none

package nco_csr_pkg;

   localparam int CSR_ADDR_W = 2;

   typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
   typedef logic [31:0]           csr_data_t;

   // register map
   localparam csr_addr_t ADDR_CTRL   = 2'd0;
   localparam csr_addr_t ADDR_PERIOD = 2'd1;
   localparam csr_addr_t ADDR_STATUS = 2'd2;

   // CTRL bits
   localparam int CTRL_EN_BIT   = 0;
   localparam int CTRL_SRST_BIT = 1;

   // STATUS bits
   localparam int STAT_FULL_BIT = 0;
   localparam int STAT_OVF_BIT  = 1;

endpackage

`default_nettype wire

// File: verilog/nco_fmt_pkg.sv
`default_nettype none

package nco_fmt_pkg;

   // period width in clk_in_i cycles, unsigned fixed point
   localparam int PERIOD_W = 16;

   // fractional bits, so 1.0 is 1 << FRAC_W
   localparam int FRAC_W = 8;

   // one guard bit above the period for the add before the compare
   localparam int ACC_W = PERIOD_W + 1;

   // one period value, integer part above FRAC_W
   typedef logic [PERIOD_W-1:0] period_t;

   // phase accumulator
   typedef logic [ACC_W-1:0] acc_t;

endpackage

`default_nettype wire
